/* files.f */
design/island_pkg.sv
design/wb_if.sv
design/bus_decoder.sv
design/sram_bank.sv
design/soc_ctrl_regs.sv
design/island_top.sv
sim/tb_island_top.sv

/* run.sh */
#!/bin/sh
# Build and run the island testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_island_top -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_island_top 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

/* sim/tb_island_top.sv */
// ------------------------------------------------
// Testbench for the safety island
//   Clock, reset and Wishbone master task
//   Bank and register model with exp_read
//   Directed and random tests, summary
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_island_top;

  localparam logic [31:0] BaseAddr    = island_pkg::DefaultBaseAddr;
  localparam logic [31:0] BankBytes   = island_pkg::DefaultBankNumBytes;
  localparam logic [31:0] DataStart   = BaseAddr + BankBytes;
  localparam logic [31:0] DataEnd     = DataStart + BankBytes;
  localparam logic [31:0] PeriphStart = BaseAddr + island_pkg::PeriphOffset;
  localparam logic [31:0] CtrlStart   = PeriphStart + island_pkg::SocCtrlOffset;
  localparam logic [31:0] CtrlEnd     = CtrlStart + island_pkg::SocCtrlNumBytes;
  localparam int          Timeout     = 20;

  logic        clk_i = 1'b0;
  logic        rst_ni, wb_cyc_i, wb_stb_i, wb_we_i;
  logic [3:0]  wb_sel_i;
  logic [31:0] wb_adr_i, wb_dat_i, wb_dat_o;
  logic        wb_ack_o, wb_err_o, fetch_enable_o;
  logic [31:0] boot_addr_o;

  // Reference state
  logic [31:0] mem_model [logic [31:0]];
  logic        fetch_model = 1'b0;
  logic [31:0] boot_model  = BaseAddr;

  // Snapshot of the last access for the compare process
  event        access_done;
  event        timeout_ev;
  logic        cmp_we, cmp_ack, cmp_err, cmp_exp_err;
  logic [31:0] cmp_adr, cmp_dat, cmp_exp_dat;
  int          cmp_lat;

  string       test_name;
  int          test_errs = 0;
  int          lat_bad   = 0;
  int          n_pass    = 0;
  int          n_fail    = 0;
  logic        timed_out = 1'b0;
  integer      seed      = 32'h3cb2;

  always #10 clk_i = ~clk_i;

  island_top #(
    .BaseAddr     ( BaseAddr                       ),
    .BankNumBytes ( island_pkg::DefaultBankNumBytes )
  ) i_island_top (.*);

  // Expected read data and error flag from the map and the model
  function automatic void exp_read(input logic [31:0] adr, output logic [31:0] dat,
                                   output logic err);
    logic [31:0] wadr;
    wadr = {adr[31:2], 2'b00};
    err  = 1'b0;
    dat  = '0;
    if (adr >= BaseAddr && adr < DataEnd) begin
      if (mem_model.exists(wadr)) begin
        dat = mem_model[wadr];
      end
    end else if (adr >= CtrlStart && adr < CtrlEnd) begin
      if (adr[11:2] == 10'd0) begin
        dat = {31'b0, fetch_model};
      end else if (adr[11:2] == 10'd1) begin
        dat = boot_model;
      end else begin
        err = 1'b1;
      end
    end else begin
      err = 1'b1;
      dat = island_pkg::ErrorWord;
    end
  endfunction

  // Byte merge into the addressed word, unmapped writes are dropped
  function automatic void model_write(input logic [31:0] adr, input logic [3:0] sel,
                                      input logic [31:0] dat);
    logic [31:0] word;
    logic        err;
    exp_read(adr, word, err);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) word[b*8 +: 8] = dat[b*8 +: 8];
    end
    if (adr >= BaseAddr && adr < DataEnd) begin
      mem_model[{adr[31:2], 2'b00}] = word;
    end else if (!err && adr[11:2] == 10'd0) begin
      fetch_model = word[0];
    end else if (!err) begin
      boot_model = word;
    end
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp) else begin
      $display("FAILED %s: %s expected %h actual %h", test_name, what, exp, got);
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
      n_pass++;
    end else begin
      $display("test %s: %0d errors", test_name, test_errs);
      n_fail++;
    end
  endtask

  // One Wishbone classic access, request held until ack or err
  task automatic do_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                           input logic [31:0] dat);
    logic [31:0] e_dat;
    logic        e_err;
    int          cycles;
    exp_read(adr, e_dat, e_err);
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_sel_i = sel;
    wb_adr_i = adr;
    wb_dat_i = dat;
    cycles   = 0;
    cmp_ack  = 1'b0;
    cmp_err  = 1'b0;
    // Sampled on the falling edge, half a cycle from any driving edge
    while (!cmp_ack && !cmp_err && cycles < Timeout) begin
      @(negedge clk_i);
      cycles++;
      cmp_ack = wb_ack_o;
      cmp_err = wb_err_o;
      cmp_dat = wb_dat_o;
    end
    if (!cmp_ack && !cmp_err) begin
      timed_out = 1'b1;
      -> timeout_ev;
    end
    cmp_we      = we;
    cmp_adr     = adr;
    cmp_exp_dat = e_dat;
    cmp_exp_err = e_err;
    // First falling edge comes before the first rising edge
    cmp_lat     = cycles - 1;
    -> access_done;
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (we) model_write(adr, sel, dat);
  endtask

  // Register write, then status outputs and readback
  task automatic ctrl_write(input logic [31:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat);
    do_access(1'b1, sel, adr, dat);
    check_value("fetch_enable_o", {31'b0, fetch_model}, {31'b0, fetch_enable_o});
    check_value("boot_addr_o", boot_model, boot_addr_o);
    do_access(1'b0, 4'hf, adr, 32'h0);
  endtask

  // ------------------------------------------------
  // Compare process
  // ------------------------------------------------
  always @(access_done) begin
    check_value($sformatf("{err,ack} @%h", cmp_adr), {30'b0, cmp_exp_err, ~cmp_exp_err},
                {30'b0, cmp_err, cmp_ack});
    if (!cmp_we) begin
      check_value($sformatf("read data @%h", cmp_adr), cmp_exp_dat, cmp_dat);
    end
    assert (cmp_lat == 1) else begin
      $display("FAILED %s: latency @%h expected 1 actual %0d", test_name, cmp_adr, cmp_lat);
      test_errs++;
      lat_bad++;
    end
  end

  initial begin
    @(timeout_ev);
    $display("ERROR: %s: no ack or err within %0d cycles at address %h",
             test_name, Timeout, wb_adr_i);
    $display("Verification failed");
    $finish;
  end

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial begin
    logic [31:0] adr;
    logic [31:0] r_adr, r_ctl, r_dat;
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_sel_i = 4'h0;
    wb_adr_i = 32'h0;
    wb_dat_i = 32'h0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    start_test("reset state");
    check_value("ack and err", 32'h0, {30'b0, wb_ack_o, wb_err_o});
    check_value("fetch_enable_o", 32'h0, {31'b0, fetch_enable_o});
    check_value("boot_addr_o", BaseAddr, boot_addr_o);
    do_access(1'b0, 4'hf, CtrlStart, 32'h0);
    do_access(1'b0, 4'hf, CtrlStart + 32'd4, 32'h0);
    finish_test();

    lat_bad = 0;
    start_test("bank byte-enable access");
    for (int i = 0; i < 8; i++) begin
      do_access(1'b1, 4'hf, BaseAddr + 32'(i * 4), {4{8'(i) ^ 8'h3C}});
      do_access(1'b1, 4'hf, DataStart + 32'(i * 4), {4{8'(i) ^ 8'hC3}});
      do_access(1'b1, 4'(i + 1), BaseAddr + 32'(i * 4), 32'hA5B6_C7D8);
      do_access(1'b1, ~4'(i + 1), DataStart + 32'(i * 4), 32'h1E2D_3C4B);
    end
    for (int i = 0; i < 8; i++) begin
      do_access(1'b0, 4'hf, BaseAddr + 32'(i * 4), 32'h0);
      do_access(1'b0, 4'hf, DataStart + 32'(i * 4), 32'h0);
    end
    finish_test();

    start_test("SoC control");
    ctrl_write(CtrlStart, 4'hf, 32'hFFFF_FFFF);
    ctrl_write(CtrlStart, 4'b1110, 32'h0000_0000);
    ctrl_write(CtrlStart, 4'b0001, 32'h0000_0002);
    ctrl_write(CtrlStart, 4'b0001, 32'h0000_0001);
    ctrl_write(CtrlStart + 32'd4, 4'hf, 32'h2000_0100);
    ctrl_write(CtrlStart + 32'd4, 4'b0101, 32'hAABB_CCDD);
    ctrl_write(CtrlStart + 32'd4, 4'b1000, 32'h7700_0000);
    finish_test();

    // Bit 0 clear and unlike the boot address, so a leaked write shows
    start_test("error responses");
    for (int k = 0; k < 4; k++) begin
      adr = (k == 0) ? BaseAddr - 32'd4 :
            (k == 1) ? DataEnd + 32'h100 :
            (k == 2) ? CtrlEnd + 32'h40 : CtrlStart + 32'h8;
      ctrl_write(adr, 4'hf, 32'h5A5A_5A5A);
    end
    do_access(1'b0, 4'hf, BaseAddr, 32'h0);
    do_access(1'b0, 4'hf, DataStart, 32'h0);
    do_access(1'b0, 4'hf, CtrlStart, 32'h0);
    do_access(1'b0, 4'hf, CtrlStart + 32'd4, 32'h0);
    finish_test();

    start_test("single-cycle response");
    test_errs = lat_bad;
    finish_test();

    start_test("random traffic");
    for (int i = 0; i < 16; i++) begin
      r_dat = $random(seed);
      do_access(1'b1, 4'hf, BaseAddr + 32'(i * 4), r_dat);
      r_dat = $random(seed);
      do_access(1'b1, 4'hf, DataStart + 32'(i * 4), r_dat);
    end
    for (int i = 0; i < 300; i++) begin
      r_ctl = $random(seed);
      r_adr = $random(seed);
      r_dat = $random(seed);
      if (r_ctl[31:8] % 24'd100 < 24'd80) begin
        case (r_adr[5:4])
          2'd0:    adr = BaseAddr + {26'b0, r_adr[3:0], 2'b00};
          2'd1:    adr = DataStart + {26'b0, r_adr[3:0], 2'b00};
          default: adr = CtrlStart + {29'b0, r_adr[0], 2'b00};
        endcase
      end else begin
        // Anywhere else, kept off unwritten bank words
        adr = {r_adr[31:2], 2'b00};
        if (adr >= BaseAddr && adr < DataEnd) adr[31] = 1'b1;
      end
      do_access(r_ctl[4], r_ctl[3:0], adr, r_dat);
    end
    finish_test();

    $display("Summary: %0d tests ok, %0d tests failed", n_pass, n_fail);
    if (n_fail == 0 && !timed_out) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/island_top.sv */
// ------------------------------------------------
// Safety island memory-mapped core
//   External Wishbone classic port
//   Address decoder with error responder
//   Instruction and data SRAM banks
//   SoC control registers driving core status
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module island_top #(
  parameter island_pkg::addr_t BaseAddr     = island_pkg::DefaultBaseAddr,
  parameter int unsigned       BankNumBytes = island_pkg::DefaultBankNumBytes
) (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Wishbone slave port
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  island_pkg::sel_t  wb_sel_i,
  input  island_pkg::addr_t wb_adr_i,
  input  island_pkg::data_t wb_dat_i,
  output island_pkg::data_t wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o,

  // Core status
  output logic              fetch_enable_o,
  output island_pkg::addr_t boot_addr_o
);

  localparam int unsigned BankNumWords = BankNumBytes / 4;

  wb_if instr_bus ();
  wb_if data_bus ();
  wb_if ctrl_bus ();

  // Data bank is placed at BaseAddr + BankNumBytes by the decoder
  bus_decoder #(
    .BaseAddr     ( BaseAddr     ),
    .BankNumBytes ( BankNumBytes )
  ) i_bus_decoder (
    .clk_i,
    .rst_ni,
    .wb_cyc_i,
    .wb_stb_i,
    .wb_we_i,
    .wb_sel_i,
    .wb_adr_i,
    .wb_dat_i,
    .wb_dat_o,
    .wb_ack_o,
    .wb_err_o,
    .instr_o ( instr_bus.master ),
    .data_o  ( data_bus.master  ),
    .ctrl_o  ( ctrl_bus.master  )
  );

  sram_bank #(
    .NumWords ( BankNumWords )
  ) i_instr_mem (
    .clk_i,
    .rst_ni,
    .bus_i ( instr_bus.slave )
  );

  sram_bank #(
    .NumWords ( BankNumWords )
  ) i_data_mem (
    .clk_i,
    .rst_ni,
    .bus_i ( data_bus.slave )
  );

  soc_ctrl_regs #(
    .BaseAddr ( BaseAddr )
  ) i_soc_ctrl (
    .clk_i,
    .rst_ni,
    .bus_i          ( ctrl_bus.slave ),
    .fetch_enable_o,
    .boot_addr_o
  );

endmodule

`default_nettype wire

/* design/soc_ctrl_regs.sv */
// ------------------------------------------------
// SoC control register block
//   REG_FETCHEN: core fetch enable, bit 0
//   REG_BOOTADDR: core boot address
//   Unused offsets answer with err
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_regs #(
  parameter island_pkg::addr_t BaseAddr = island_pkg::DefaultBaseAddr
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  wb_if.slave               bus_i,
  output logic              fetch_enable_o,
  output island_pkg::addr_t boot_addr_o
);

  // Core boots from the start of the instruction bank
  localparam island_pkg::addr_t BootAddrResetVal = BaseAddr;

  logic [9:0]        word_off;
  logic              hit_fetchen;
  logic              hit_bootaddr;
  logic              req;
  logic              ack_q;
  logic              err_q;
  logic              fetch_en_q;
  island_pkg::addr_t boot_addr_q;
  island_pkg::data_t rdata;
  island_pkg::data_t rdata_q;

  assign req = bus_i.cyc & bus_i.stb & ~(ack_q | err_q);

  // Register decode on address bits 11:2
  assign word_off     = bus_i.adr[11:2];
  assign hit_fetchen  = (word_off == 10'(island_pkg::REG_FETCHEN));
  assign hit_bootaddr = (word_off == 10'(island_pkg::REG_BOOTADDR));

  always_comb begin
    rdata = '0;
    if (hit_fetchen) begin
      rdata[0] = fetch_en_q;
    end else if (hit_bootaddr) begin
      rdata = boot_addr_q;
    end
  end

  // ------------------------------------------------
  // Registers
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q  <= island_pkg::FetchEnResetVal;
      boot_addr_q <= BootAddrResetVal;
    end else if (req && bus_i.we) begin
      // Only bit 0 is kept, in byte lane 0
      if (hit_fetchen && bus_i.sel[0]) begin
        fetch_en_q <= bus_i.dat_w[0];
      end
      if (hit_bootaddr) begin
        for (int b = 0; b < island_pkg::SelWidth; b++) begin
          if (bus_i.sel[b]) begin
            boot_addr_q[b*8 +: 8] <= bus_i.dat_w[b*8 +: 8];
          end
        end
      end
    end
  end

  // ------------------------------------------------
  // Response
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req & (hit_fetchen | hit_bootaddr);
      err_q <= req & ~(hit_fetchen | hit_bootaddr);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      rdata_q <= rdata;
    end
  end

  assign bus_i.ack      = ack_q;
  assign bus_i.err      = err_q;
  assign bus_i.dat_r    = rdata_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bus_i.ack && bus_i.err));

endmodule

`default_nettype wire

/* design/sram_bank.sv */
// ------------------------------------------------
// Single-port SRAM bank with Wishbone slave port
//   Word addressed, wraps modulo NumWords
//   Byte-enable writes
//   Registered read data and one-cycle ack
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
  parameter int unsigned NumWords = 8192
) (
  input  logic clk_i,
  input  logic rst_ni,
  wb_if.slave  bus_i
);

  localparam int unsigned IdxWidth = (NumWords > 1) ? $clog2(NumWords) : 1;

  typedef logic [IdxWidth-1:0] idx_t;

  island_pkg::data_t mem_q [NumWords];
  island_pkg::data_t rdata_q;
  logic              ack_q;
  logic              req;
  idx_t              idx;

  // New request only while no ack is pending for the held one
  assign req = bus_i.cyc & bus_i.stb & ~ack_q;

  // Word index, byte offset dropped
  assign idx = idx_t'(bus_i.adr[island_pkg::AddrWidth-1:2] % NumWords);

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req) begin
      if (bus_i.we) begin
        for (int b = 0; b < island_pkg::SelWidth; b++) begin
          if (bus_i.sel[b]) begin
            mem_q[idx][b*8 +: 8] <= bus_i.dat_w[b*8 +: 8];
          end
        end
      end
      rdata_q <= mem_q[idx];
    end
  end

  // ------------------------------------------------
  // Handshake
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  assign bus_i.ack   = ack_q;
  assign bus_i.err   = 1'b0;
  assign bus_i.dat_r = rdata_q;

  // One ack per request, even with stb held high
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_i.ack |=> !bus_i.ack);

endmodule

`default_nettype wire

/* design/bus_decoder.sv */
// ------------------------------------------------
// Island address decoder
//   Main map: instruction bank, data bank, peripherals
//   Peripheral map: SoC control or error response
//   Strobe routing and response multiplexing
//   Built-in error responder for unmapped addresses
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module bus_decoder #(
  parameter island_pkg::addr_t BaseAddr     = island_pkg::DefaultBaseAddr,
  parameter int unsigned       BankNumBytes = island_pkg::DefaultBankNumBytes
) (
  input  logic              clk_i,
  input  logic              rst_ni,

  // External master
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  island_pkg::sel_t  wb_sel_i,
  input  island_pkg::addr_t wb_adr_i,
  input  island_pkg::data_t wb_dat_i,
  output island_pkg::data_t wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o,

  // Targets
  wb_if.master              instr_o,
  wb_if.master              data_o,
  wb_if.master              ctrl_o
);

  // ------------------------------------------------
  // Window bounds, end addresses exclusive
  // ------------------------------------------------
  localparam island_pkg::addr_t BankBytes   = island_pkg::addr_t'(BankNumBytes);
  localparam island_pkg::addr_t InstrStart  = BaseAddr;
  localparam island_pkg::addr_t DataStart   = BaseAddr + BankBytes;
  localparam island_pkg::addr_t DataEnd     = DataStart + BankBytes;
  localparam island_pkg::addr_t PeriphStart = BaseAddr + island_pkg::PeriphOffset;
  localparam island_pkg::addr_t PeriphEnd   = PeriphStart + island_pkg::PeriphNumBytes;
  localparam island_pkg::addr_t CtrlStart   = PeriphStart + island_pkg::SocCtrlOffset;
  localparam island_pkg::addr_t CtrlEnd     = CtrlStart + island_pkg::SocCtrlNumBytes;

  island_pkg::target_e tgt;
  logic                req;
  logic                err_q;

  assign req = wb_cyc_i & wb_stb_i;

  // Main map first, then the peripheral map inside its window
  always_comb begin
    tgt = island_pkg::TGT_ERROR;
    if (wb_adr_i >= InstrStart && wb_adr_i < DataStart) begin
      tgt = island_pkg::TGT_INSTR;
    end else if (wb_adr_i >= DataStart && wb_adr_i < DataEnd) begin
      tgt = island_pkg::TGT_DATA;
    end else if (wb_adr_i >= PeriphStart && wb_adr_i < PeriphEnd) begin
      if (wb_adr_i >= CtrlStart && wb_adr_i < CtrlEnd) begin
        tgt = island_pkg::TGT_SOC_CTRL;
      end
    end
  end

  // ------------------------------------------------
  // Request routing
  // ------------------------------------------------
  // Only stb is steered, the rest is shared by all targets
  assign instr_o.cyc   = wb_cyc_i;
  assign instr_o.stb   = req & (tgt == island_pkg::TGT_INSTR);
  assign instr_o.we    = wb_we_i;
  assign instr_o.sel   = wb_sel_i;
  assign instr_o.adr   = wb_adr_i;
  assign instr_o.dat_w = wb_dat_i;

  assign data_o.cyc    = wb_cyc_i;
  assign data_o.stb    = req & (tgt == island_pkg::TGT_DATA);
  assign data_o.we     = wb_we_i;
  assign data_o.sel    = wb_sel_i;
  assign data_o.adr    = wb_adr_i;
  assign data_o.dat_w  = wb_dat_i;

  assign ctrl_o.cyc    = wb_cyc_i;
  assign ctrl_o.stb    = req & (tgt == island_pkg::TGT_SOC_CTRL);
  assign ctrl_o.we     = wb_we_i;
  assign ctrl_o.sel    = wb_sel_i;
  assign ctrl_o.adr    = wb_adr_i;
  assign ctrl_o.dat_w  = wb_dat_i;

  // Error responder, one err pulse per unmapped request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req & (tgt == island_pkg::TGT_ERROR) & ~err_q;
    end
  end

  // ------------------------------------------------
  // Response multiplexing
  // ------------------------------------------------
  // The master holds the address until the response, so the
  // current decode still points at the answering target
  always_comb begin
    case (tgt)
      island_pkg::TGT_INSTR: begin
        wb_dat_o = instr_o.dat_r;
        wb_ack_o = instr_o.ack;
        wb_err_o = instr_o.err;
      end
      island_pkg::TGT_DATA: begin
        wb_dat_o = data_o.dat_r;
        wb_ack_o = data_o.ack;
        wb_err_o = data_o.err;
      end
      island_pkg::TGT_SOC_CTRL: begin
        wb_dat_o = ctrl_o.dat_r;
        wb_ack_o = ctrl_o.ack;
        wb_err_o = ctrl_o.err;
      end
      default: begin
        wb_dat_o = island_pkg::ErrorWord;
        wb_ack_o = 1'b0;
        wb_err_o = err_q;
      end
    endcase
  end

  // Selected target never answers both ways at once
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_ack_o && wb_err_o));

  // External master keeps stb inside a bus cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_i |-> wb_cyc_i);

endmodule

`default_nettype wire

/* design/wb_if.sv */
// ------------------------------------------------
// Wishbone classic bus between decoder and targets
//   master modport: request side
//   slave modport: response side
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface wb_if;

  // Request
  logic               cyc;
  logic               stb;
  logic               we;
  island_pkg::sel_t   sel;
  island_pkg::addr_t  adr;
  island_pkg::data_t  dat_w;

  // Response, valid only together with ack or err
  island_pkg::data_t  dat_r;
  logic               ack;
  logic               err;

  modport master (
    output cyc,
    output stb,
    output we,
    output sel,
    output adr,
    output dat_w,
    input  dat_r,
    input  ack,
    input  err
  );

  modport slave (
    input  cyc,
    input  stb,
    input  we,
    input  sel,
    input  adr,
    input  dat_w,
    output dat_r,
    output ack,
    output err
  );

endinterface

`default_nettype wire

/* design/island_pkg.sv */
// ------------------------------------------------
// Safety island shared definitions
//   Bus widths and word types
//   Default placement of the island and its banks
//   Peripheral and SoC control windows
//   Decode targets and SoC control register map
// ------------------------------------------------

`default_nettype none

package island_pkg;

  // ------------------------------------------------
  // Bus widths
  // ------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SelWidth  = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [SelWidth-1:0]  sel_t;

  // ------------------------------------------------
  // Address map
  // ------------------------------------------------
  // Instruction bank sits at the base, data bank right after it
  localparam addr_t       DefaultBaseAddr     = 32'h1000_0000;
  localparam int unsigned DefaultBankNumBytes = 32'h0000_8000;

  // Peripheral window, relative to the island base
  localparam addr_t PeriphOffset   = 32'h0002_0000;
  localparam addr_t PeriphNumBytes = 32'h0000_8000;

  // SoC control window, relative to the peripheral window
  localparam addr_t SocCtrlOffset   = 32'h0000_0000;
  localparam addr_t SocCtrlNumBytes = 32'h0000_1000;

  // Read data of any unmapped access
  localparam data_t ErrorWord = 32'hBADCAB1E;

  // ------------------------------------------------
  // Decode targets
  // ------------------------------------------------
  typedef enum logic [1:0] {
    TGT_INSTR    = 2'd0,
    TGT_DATA     = 2'd1,
    TGT_SOC_CTRL = 2'd2,
    TGT_ERROR    = 2'd3
  } target_e;

  // ------------------------------------------------
  // SoC control registers (word offsets)
  // ------------------------------------------------
  typedef enum logic [0:0] {
    REG_FETCHEN  = 1'b0,  // byte offset 0
    REG_BOOTADDR = 1'b1   // byte offset 4
  } ctrl_reg_e;

  localparam logic FetchEnResetVal = 1'b0;

endpackage

`default_nettype wire
